// ==== Bender.yml ====
package:
  name: video_pixel_gen

sources:
  - source/PixelGenPkg.sv
  - source/DrawPosition.sv
  - source/DotSquareLayer.sv
  - source/SceneFade.sv
  - source/PixelFifo.sv
  - source/VideoPixelGen.sv
  - target: simulation
    files:
      - testbench/VideoPixelGen_sva.sv
      - testbench/VideoPixelGenTb.sv

// ==== all.f ====
source/PixelGenPkg.sv
source/DrawPosition.sv
source/DotSquareLayer.sv
source/SceneFade.sv
source/PixelFifo.sv
source/VideoPixelGen.sv
testbench/VideoPixelGen_sva.sv
testbench/VideoPixelGenTb.sv

// ==== source/DotSquareLayer.sv ====
`timescale 1ns/1ns
// paints up to three solid rectangles over the background color, one register stage
module DotSquareLayer
	import PixelGenPkg::*;
(
	input  logic     iCLK,
	input  logic     reset,
	input  logic     pixelIssue,
	input  hPosType  hPos,
	input  vPosType  vPos,
	input  logic     frameLast,
	input  colorType squareColor1,
	input  coordType squareLeft1,
	input  coordType squareRight1,
	input  coordType squareTop1,
	input  coordType squareUnder1,
	input  colorType squareColor2,
	input  coordType squareLeft2,
	input  coordType squareRight2,
	input  coordType squareTop2,
	input  coordType squareUnder2,
	input  colorType squareColor3,
	input  coordType squareLeft3,
	input  coordType squareRight3,
	input  coordType squareTop3,
	input  coordType squareUnder3,
	output logic     squareValid,
	output colorType squareColor,
	output logic     squareLast
);

	coordType xPos;
	coordType yPos;
	logic hit1;
	logic hit2;
	logic hit3;
	colorType paintColor;

	// inclusive bounds, an inverted rectangle never matches
	function automatic logic inSquare(
		input coordType x,
		input coordType y,
		input coordType left,
		input coordType right,
		input coordType top,
		input coordType under
	);
		return (x >= left) && (x <= right) && (y >= top) && (y <= under);
	endfunction

	// screen position as signed coordinate
	assign xPos = coordType'(hPos);
	assign yPos = coordType'(vPos);

	assign hit1 = inSquare(xPos, yPos, squareLeft1, squareRight1, squareTop1, squareUnder1);
	assign hit2 = inSquare(xPos, yPos, squareLeft2, squareRight2, squareTop2, squareUnder2);
	assign hit3 = inSquare(xPos, yPos, squareLeft3, squareRight3, squareTop3, squareUnder3);

	// --------------------
	// priority select
	// --------------------
	// lowest number wins
	always_comb
	begin
		if (hit1)
			paintColor = squareColor1;
		else if (hit2)
			paintColor = squareColor2;
		else if (hit3)
			paintColor = squareColor3;
		else
			paintColor = backgroundColor;
	end

	// stage flags
	always_ff @(posedge iCLK)
	begin
		if (reset)
		begin
			squareValid <= 1'b0;
			squareLast <= 1'b0;
		end
		else
		begin
			squareValid <= pixelIssue;
			squareLast <= frameLast;
		end
	end

	// color held between pixels
	always_ff @(posedge iCLK)
	begin
		if (pixelIssue)
			squareColor <= paintColor;
	end

endmodule

// ==== source/DrawPosition.sv ====
`timescale 1ns/1ns
// raster walk over the display, issues one pixel position per cycle while the FIFO has room
module DrawPosition
	import PixelGenPkg::*;
(
	input  logic         iCLK,
	input  logic         reset,
	input  fifoCountType fifoCount,
	output logic         pixelIssue,
	output hPosType      hPos,
	output vPosType      vPos,
	output logic         frameLast
);

	logic advance;
	logic lineEnd;
	logic frameEnd;

	// stall once the fifo reaches its almost-full level
	assign advance = fifoCount < fifoAlmostFull;

	assign lineEnd = hPos == hPosType'(hActive - 1);
	assign frameEnd = vPos == vPosType'(vActive - 1);

	// issued pixel is the last of the frame
	assign frameLast = pixelIssue && lineEnd && frameEnd;

	// --------------------
	// position counters
	// --------------------
	always_ff @(posedge iCLK)
	begin
		if (reset)
		begin
			pixelIssue <= 1'b0;
			// park on the last pixel, first issue is (0, 0)
			hPos <= hPosType'(hActive - 1);
			vPos <= vPosType'(vActive - 1);
		end
		else
		begin
			pixelIssue <= advance;
			if (advance)
			begin
				if (lineEnd)
				begin
					hPos <= '0;
					// wrap to top after last line
					vPos <= frameEnd ? '0 : vPos + 1'b1;
				end
				else
				begin
					hPos <= hPos + 1'b1;
				end
			end
		end
	end

endmodule

// ==== source/PixelFifo.sv ====
`timescale 1ns/1ns
// output FIFO of finished pixels, popped by a read strobe, reports its fill to the raster walk
module PixelFifo
	import PixelGenPkg::*;
(
	input  logic         iCLK,
	input  logic         reset,
	input  logic         fadeValid,
	input  colorType     fadeColor,
	input  logic         fadeLast,
	input  logic         readStrobe,
	output fifoCountType fifoCount,
	output colorType     pixelData,
	output logic         pixelValid,
	output logic         frameEnd
);

	fifoWordType mem [fifoDepth];
	logic [$clog2(fifoDepth)-1:0] wrPtr;
	logic [$clog2(fifoDepth)-1:0] rdPtr;
	logic wrEn;
	logic rdEn;

	// full never happens with almost-full margin
	assign wrEn = fadeValid && (fifoCount != fifoDepth);
	// strobe on empty fifo ignored
	assign rdEn = readStrobe && (fifoCount != '0);

	// --------------------
	// pointers and count
	// --------------------
	always_ff @(posedge iCLK)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			fifoCount <= '0;
			pixelValid <= 1'b0;
			frameEnd <= 1'b0;
		end
		else
		begin
			if (wrEn)
				wrPtr <= wrPtr + 1'b1;
			if (rdEn)
				rdPtr <= rdPtr + 1'b1;
			case ({wrEn, rdEn})
				2'b10: fifoCount <= fifoCount + 1'b1;
				2'b01: fifoCount <= fifoCount - 1'b1;
				default: fifoCount <= fifoCount;
			endcase
			// one cycle after accepted read
			pixelValid <= rdEn;
			frameEnd <= rdEn && mem[rdPtr].last;
		end
	end

	// storage and read data
	always_ff @(posedge iCLK)
	begin
		if (wrEn)
			mem[wrPtr] <= '{last: fadeLast, color: fadeColor};
		if (rdEn)
			pixelData <= mem[rdPtr].color;
	end

endmodule

// ==== source/PixelGenPkg.sv ====
// shared sizes, pixel types and FIFO limits of the pixel generator, imported by each module
package PixelGenPkg;

	// --------------------
	// display raster
	// --------------------
	localparam int hActive = 16;
	localparam int vActive = 8;
	localparam int hPosWidth = 4;
	localparam int vPosWidth = 3;

	typedef logic [hPosWidth-1:0] hPosType;
	typedef logic [vPosWidth-1:0] vPosType;

	// rectangle bound, signed so it can sit off screen
	typedef logic signed [5:0] coordType;

	// --------------------
	// color and fade
	// --------------------
	// rgb565, red in the top bits
	typedef logic [15:0] colorType;

	// dark grey under every uncovered pixel
	localparam colorType backgroundColor = 16'h18e3;

	// fade level runs 0 .. alphaFull
	localparam int alphaFull = 32;
	typedef logic [5:0] alphaType;

	// --------------------
	// output fifo
	// --------------------
	localparam int fifoDepth = 32;
	// raster stalls at this fill, leaving room for pixels in flight
	localparam int fifoAlmostFull = 24;

	typedef logic [$clog2(fifoDepth):0] fifoCountType;

	typedef struct packed
	{
		logic last;
		colorType color;
	} fifoWordType;

endpackage

// ==== source/SceneFade.sv ====
`timescale 1ns/1ns
// steps a per-frame fade level and blends each pixel toward the scene color, one register stage
module SceneFade
	import PixelGenPkg::*;
(
	input  logic       iCLK,
	input  logic       reset,
	input  logic       squareValid,
	input  colorType   squareColor,
	input  logic       squareLast,
	input  colorType   sceneColor,
	input  logic [6:0] sceneFrameTiming,
	input  logic       sceneFrameAddEn,
	input  logic       sceneFrameSubEn,
	input  logic       sceneFrameReset,
	output logic       fadeValid,
	output colorType   fadeColor,
	output logic       fadeLast,
	output logic       alphaMax,
	output logic       alphaMin
);

	alphaType level;
	logic [6:0] frameCount;
	logic frameStep;
	logic timingHit;
	logic [5:0] mixRed;
	logic [5:0] mixGreen;
	logic [5:0] mixBlue;

	// (src * (32 - a) + scene * a) >> 5
	function automatic logic [5:0] blendChannel(
		input logic [5:0] src,
		input logic [5:0] scene,
		input alphaType alpha
	);
		logic [5:0] keep;
		logic [11:0] mix;
		keep = alphaType'(alphaFull) - alpha;
		mix = 12'(src) * 12'(keep) + 12'(scene) * 12'(alpha);
		// sum stays below 2048
		return mix[10:5];
	endfunction

	// frame-last pixel passing through
	assign frameStep = squareValid && squareLast;
	assign timingHit = frameCount == sceneFrameTiming;

	assign alphaMax = level == alphaType'(alphaFull);
	assign alphaMin = level == '0;

	// --------------------
	// fade level control
	// --------------------
	always_ff @(posedge iCLK)
	begin
		if (reset || sceneFrameReset)
		begin
			level <= '0;
			frameCount <= '0;
		end
		else if (frameStep)
		begin
			if (timingHit)
			begin
				frameCount <= '0;
				// add wins over sub, both saturate
				if (sceneFrameAddEn)
				begin
					if (!alphaMax)
						level <= level + 1'b1;
				end
				else if (sceneFrameSubEn)
				begin
					if (!alphaMin)
						level <= level - 1'b1;
				end
			end
			else
			begin
				frameCount <= frameCount + 1'b1;
			end
		end
	end

	// --------------------
	// blend
	// --------------------
	// 5-bit red and blue padded to 6
	always_comb
	begin
		mixRed = blendChannel({1'b0, squareColor[15:11]}, {1'b0, sceneColor[15:11]}, level);
		mixGreen = blendChannel(squareColor[10:5], sceneColor[10:5], level);
		mixBlue = blendChannel({1'b0, squareColor[4:0]}, {1'b0, sceneColor[4:0]}, level);
	end

	always_ff @(posedge iCLK)
	begin
		if (reset)
		begin
			fadeValid <= 1'b0;
			fadeLast <= 1'b0;
		end
		else
		begin
			fadeValid <= squareValid;
			fadeLast <= squareLast;
		end
	end

	// frame-last pixel still sees old level here
	always_ff @(posedge iCLK)
	begin
		if (squareValid)
			fadeColor <= {mixRed[4:0], mixGreen, mixBlue[4:0]};
	end

endmodule

// ==== source/VideoPixelGen.sv ====
`timescale 1ns/1ns
// top level of the pixel generator, chains raster walk, rectangles, fade and output FIFO
module VideoPixelGen
	import PixelGenPkg::*;
(
	input  logic       iCLK,
	input  logic       reset,
	input  colorType   squareColor1,
	input  coordType   squareLeft1,
	input  coordType   squareRight1,
	input  coordType   squareTop1,
	input  coordType   squareUnder1,
	input  colorType   squareColor2,
	input  coordType   squareLeft2,
	input  coordType   squareRight2,
	input  coordType   squareTop2,
	input  coordType   squareUnder2,
	input  colorType   squareColor3,
	input  coordType   squareLeft3,
	input  coordType   squareRight3,
	input  coordType   squareTop3,
	input  coordType   squareUnder3,
	input  colorType   sceneColor,
	input  logic [6:0] sceneFrameTiming,
	input  logic       sceneFrameAddEn,
	input  logic       sceneFrameSubEn,
	input  logic       sceneFrameReset,
	input  logic       readStrobe,
	output colorType   pixelData,
	output logic       pixelValid,
	output logic       frameEnd,
	output logic       alphaMax,
	output logic       alphaMin,
	output hPosType    hPos,
	output vPosType    vPos
);

	fifoCountType fifoCount;
	logic pixelIssue;
	logic frameLast;
	logic squareValid;
	colorType squareColor;
	logic squareLast;
	logic fadeValid;
	colorType fadeColor;
	logic fadeLast;

	// --------------------
	// input side
	// --------------------
	// position also drives status outputs
	DrawPosition drawPosition (
		.iCLK(iCLK), .reset(reset),
		.fifoCount(fifoCount),
		.pixelIssue(pixelIssue),
		.hPos(hPos), .vPos(vPos),
		.frameLast(frameLast)
	);

	// --------------------
	// processing
	// --------------------
	DotSquareLayer dotSquareLayer (
		.iCLK(iCLK), .reset(reset),
		.pixelIssue(pixelIssue), .hPos(hPos), .vPos(vPos), .frameLast(frameLast),
		.squareColor1(squareColor1), .squareLeft1(squareLeft1), .squareRight1(squareRight1),
		.squareTop1(squareTop1), .squareUnder1(squareUnder1),
		.squareColor2(squareColor2), .squareLeft2(squareLeft2), .squareRight2(squareRight2),
		.squareTop2(squareTop2), .squareUnder2(squareUnder2),
		.squareColor3(squareColor3), .squareLeft3(squareLeft3), .squareRight3(squareRight3),
		.squareTop3(squareTop3), .squareUnder3(squareUnder3),
		.squareValid(squareValid), .squareColor(squareColor), .squareLast(squareLast)
	);

	SceneFade sceneFade (
		.iCLK(iCLK), .reset(reset),
		.squareValid(squareValid), .squareColor(squareColor), .squareLast(squareLast),
		.sceneColor(sceneColor),
		.sceneFrameTiming(sceneFrameTiming),
		.sceneFrameAddEn(sceneFrameAddEn),
		.sceneFrameSubEn(sceneFrameSubEn),
		.sceneFrameReset(sceneFrameReset),
		.fadeValid(fadeValid), .fadeColor(fadeColor), .fadeLast(fadeLast),
		.alphaMax(alphaMax), .alphaMin(alphaMin)
	);

	// --------------------
	// output side
	// --------------------
	// fill level throttles the raster walk
	PixelFifo pixelFifo (
		.iCLK(iCLK), .reset(reset),
		.fadeValid(fadeValid), .fadeColor(fadeColor), .fadeLast(fadeLast),
		.readStrobe(readStrobe),
		.fifoCount(fifoCount),
		.pixelData(pixelData), .pixelValid(pixelValid), .frameEnd(frameEnd)
	);

endmodule

// ==== testbench/VideoPixelGenTb.sv ====
`timescale 1ns/1ns
// testbench for the pixel generator, random scenes and read gaps checked against a pixel model
module VideoPixelGenTb
	import PixelGenPkg::*;
();

	// six frames
	localparam int framePixels = hActive * vActive;
	localparam int totalPixels = 6 * framePixels;
	// about ten times the expected run
	localparam int cycleLimit = totalPixels * 26;

	logic iCLK;
	logic reset;
	colorType rectColor [3];
	coordType rectLeft [3];
	coordType rectRight [3];
	coordType rectTop [3];
	coordType rectUnder [3];
	colorType sceneColor;
	logic [6:0] sceneFrameTiming;
	logic sceneFrameAddEn;
	logic sceneFrameSubEn;
	logic sceneFrameReset;
	logic readStrobe;
	colorType pixelData;
	logic pixelValid;
	logic frameEnd;
	logic alphaMax;
	logic alphaMin;
	hPosType hPos;
	vPosType vPos;

	// --------------------
	// model state
	// --------------------
	logic [31:0] seed = 32'd21969;
	colorType expQueue [$];
	// last issued position, parked like the DUT
	int expH = hActive - 1;
	int expV = vActive - 1;
	int occ = 0;
	int level = 0;
	int frameCount = 0;
	// level as seen by the flags, two cycles late
	int lvlD1 = 0;
	int lvlD2 = 0;
	int stableCount = 0;
	int lowLeft = 0;
	int cycle = 0;
	int received = 0;
	int checks = 0;
	logic [2:0] issueHist = 3'b000;
	logic prevAccepted = 1'b0;
	logic prevEmptyRead = 1'b0;
	logic prevAdvance = 1'b0;
	int errReset = 0;
	int errOrder = 0;
	int errColor = 0;
	int errFade = 0;
	int errFrameEnd = 0;
	int errEmpty = 0;

	VideoPixelGen DUT (
		.iCLK(iCLK), .reset(reset),
		.squareColor1(rectColor[0]), .squareLeft1(rectLeft[0]), .squareRight1(rectRight[0]),
		.squareTop1(rectTop[0]), .squareUnder1(rectUnder[0]),
		.squareColor2(rectColor[1]), .squareLeft2(rectLeft[1]), .squareRight2(rectRight[1]),
		.squareTop2(rectTop[1]), .squareUnder2(rectUnder[1]),
		.squareColor3(rectColor[2]), .squareLeft3(rectLeft[2]), .squareRight3(rectRight[2]),
		.squareTop3(rectTop[2]), .squareUnder3(rectUnder[2]),
		.sceneColor(sceneColor), .sceneFrameTiming(sceneFrameTiming),
		.sceneFrameAddEn(sceneFrameAddEn), .sceneFrameSubEn(sceneFrameSubEn),
		.sceneFrameReset(sceneFrameReset), .readStrobe(readStrobe),
		.pixelData(pixelData), .pixelValid(pixelValid), .frameEnd(frameEnd),
		.alphaMax(alphaMax), .alphaMin(alphaMin), .hPos(hPos), .vPos(vPos)
	);

	initial
	begin
		iCLK = 1'b0;
		forever
			#5 iCLK = ~iCLK;
	end

	// lcg, upper bits used
	function automatic int unsigned randomBelow(input int unsigned n);
		seed = seed * 32'd1103515245 + 32'd12345;
		return (seed >> 8) % n;
	endfunction

	// first rectangle in number order that holds the pixel
	function automatic colorType expectedPaint(input int x, input int y);
		for (int i = 0; i < 3; i++)
			if (x >= rectLeft[i] && x <= rectRight[i] && y >= rectTop[i] && y <= rectUnder[i])
				return rectColor[i];
		return backgroundColor;
	endfunction

	// pixel weighted by 32 - alpha, scene by alpha, over 32
	function automatic int mixChannel(input int pixel, input int scene, input int alpha);
		return (pixel * (alphaFull - alpha) + scene * alpha) / 32;
	endfunction

	function automatic colorType expectedFade(input colorType c, input int alpha);
		int red;
		int green;
		int blue;
		red = mixChannel(c[15:11], sceneColor[15:11], alpha);
		green = mixChannel(c[10:5], sceneColor[10:5], alpha);
		blue = mixChannel(c[4:0], sceneColor[4:0], alpha);
		return {red[4:0], green[5:0], blue[4:0]};
	endfunction

	// rectangles partly off screen, some empty
	task automatic newScene();
		int left;
		int top;
		for (int i = 0; i < 3; i++)
		begin
			left = int'(randomBelow(24)) - 4;
			top = int'(randomBelow(14)) - 3;
			rectColor[i] <= colorType'(randomBelow(65536));
			rectLeft[i] <= coordType'(left);
			rectRight[i] <= coordType'(left + int'(randomBelow(12)) - 2);
			rectTop[i] <= coordType'(top);
			rectUnder[i] <= coordType'(top + int'(randomBelow(8)) - 1);
		end
		sceneColor <= colorType'(randomBelow(65536));
		sceneFrameTiming <= 7'(randomBelow(3));
		sceneFrameAddEn <= randomBelow(3) != 0;
		sceneFrameSubEn <= randomBelow(2) == 1;
	endtask

	// --------------------
	// rising edge drive
	// --------------------
	task automatic driveInputs();
		sceneFrameReset <= 1'b0;
		// first reads hit an empty FIFO
		if (cycle < 4)
			readStrobe <= 1'b1;
		else if (lowLeft > 0)
		begin
			readStrobe <= 1'b0;
			lowLeft--;
		end
		else if (randomBelow(48) == 0)
		begin
			// long pause, FIFO fills and raster stalls
			readStrobe <= 1'b0;
			lowLeft = 16 + int'(randomBelow(40));
		end
		else
			readStrobe <= randomBelow(4) != 0;
		// scene only changes with nothing in flight
		if (stableCount >= 4)
		begin
			newScene();
			sceneFrameReset <= randomBelow(6) == 0;
			stableCount = 0;
		end
	endtask

	// --------------------
	// falling edge model and checks
	// --------------------
	task automatic sampleCycle();
		logic issued;
		// DUT fill in this cycle, write lands three cycles after issue
		if (issueHist[2])
			occ++;
		if (prevAccepted)
			occ--;
		checks++;
		if (alphaMax !== (lvlD2 == alphaFull) || alphaMin !== (lvlD2 == 0))
		begin
			errFade++;
			$display("[ERROR] %0t: flags max %b min %b, level %0d", $time, alphaMax, alphaMin, lvlD2);
		end
		if (sceneFrameReset)
		begin
			level = 0;
			frameCount = 0;
		end
		issued = (hPos != expH) || (vPos != expV);
		checks++;
		if (issued !== prevAdvance)
		begin
			errOrder++;
			$display("[ERROR] %0t: issue %b, expected %b", $time, issued, prevAdvance);
		end
		if (issued)
		begin
			stableCount = 0;
			if (expH == hActive - 1)
			begin
				expH = 0;
				expV = (expV == vActive - 1) ? 0 : expV + 1;
			end
			else
				expH++;
			checks++;
			if (hPos != expH || vPos != expV)
			begin
				errOrder++;
				$display("[ERROR] %0t: position (%0d, %0d), expected (%0d, %0d)",
					$time, hPos, vPos, expH, expV);
				expH = hPos;
				expV = vPos;
			end
			expQueue.push_back(expectedFade(expectedPaint(expH, expV), level));
			// frame-last steps the level for later pixels
			if (expH == hActive - 1 && expV == vActive - 1)
			begin
				if (frameCount == sceneFrameTiming)
				begin
					frameCount = 0;
					if (sceneFrameAddEn)
						level = (level < alphaFull) ? level + 1 : level;
					else if (sceneFrameSubEn)
						level = (level > 0) ? level - 1 : level;
				end
				else
					frameCount = (frameCount + 1) % 128;
			end
		end
		else
			stableCount++;
		checks++;
		if (pixelValid !== prevAccepted)
		begin
			if (prevEmptyRead)
				errEmpty++;
			else
				errOrder++;
			$display("[ERROR] %0t: pixelValid %b, expected %b", $time, pixelValid, prevAccepted);
		end
		if (pixelValid === 1'b1)
		begin
			received++;
			checks++;
			if (expQueue.size() == 0)
			begin
				errOrder++;
				$display("[ERROR] %0t: pixel with none expected", $time);
			end
			else if (pixelData !== expQueue[0])
			begin
				errColor++;
				$display("[ERROR] %0t: pixel %0d is %h, expected %h",
					$time, received, pixelData, expQueue[0]);
			end
			if (expQueue.size() > 0)
				void'(expQueue.pop_front());
		end
		// every 128th output pixel closes a frame
		checks++;
		if (frameEnd !== (pixelValid && (received % framePixels == 0)))
		begin
			errFrameEnd++;
			$display("[ERROR] %0t: frameEnd %b at pixel %0d", $time, frameEnd, received);
		end
		prevEmptyRead = readStrobe && occ == 0;
		prevAccepted = readStrobe && occ > 0;
		prevAdvance = occ < fifoAlmostFull;
		issueHist = {issueHist[1:0], issued};
		lvlD2 = sceneFrameReset ? 0 : lvlD1;
		lvlD1 = level;
		cycle++;
	endtask

	task automatic checkResetState();
		checks++;
		if (pixelValid !== 1'b0 || alphaMax !== 1'b0 || alphaMin !== 1'b1 ||
			hPos != hActive - 1 || vPos != vActive - 1)
		begin
			errReset++;
			$display("[ERROR] %0t: after reset valid %b max %b min %b at (%0d, %0d)",
				$time, pixelValid, alphaMax, alphaMin, hPos, vPos);
		end
	endtask

	task automatic reportTest(input string name, input int errors);
		if (errors == 0)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, errors);
	endtask

	initial
	begin
		int errors;
		reset <= 1'b1;
		readStrobe <= 1'b0;
		sceneFrameReset <= 1'b0;
		newScene();
		repeat (3)
			@(posedge iCLK);
		reset <= 1'b0;
		readStrobe <= 1'b1;
		@(negedge iCLK);
		checkResetState();
		reportTest("reset state", errReset);
		while (received < totalPixels && cycle < cycleLimit)
		begin
			sampleCycle();
			@(posedge iCLK);
			driveInputs();
			@(negedge iCLK);
		end
		if (received < totalPixels)
			$display("timeout: only %0d of %0d pixels after %0d cycles",
				received, totalPixels, cycle);
		reportTest("raster order and back-pressure", errOrder);
		reportTest("pixel colors", errColor);
		reportTest("fade flags", errFade);
		reportTest("frame end", errFrameEnd);
		reportTest("empty read", errEmpty);
		reportTest("bound assertions", DUT.fifoFadeChecks.failures);
		errors = errReset + errOrder + errColor + errFade + errFrameEnd + errEmpty;
		errors += DUT.fifoFadeChecks.failures;
		$display("checks %0d, pixels %0d of %0d, errors %0d", checks, received, totalPixels, errors);
		if (errors == 0 && received == totalPixels)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// ==== testbench/VideoPixelGen_sva.sv ====
`timescale 1ns/1ns
// concurrent checks on FIFO fill, read timing and fade flags, bound into the generator top level
module VideoPixelGenChecks
	import PixelGenPkg::*;
(
	input logic         iCLK,
	input logic         reset,
	input fifoCountType fifoCount,
	input logic         fadeValid,
	input logic         readStrobe,
	input logic         pixelValid,
	input logic         squareValid,
	input logic         squareLast,
	input logic         sceneFrameReset,
	input logic         alphaMax,
	input logic         alphaMin
);

	// count of failed assertions
	int failures = 0;

	// a write never meets a full FIFO
	noDrop: assert property (@(posedge iCLK) disable iff (reset)
		fadeValid |-> fifoCount < fifoDepth)
		else
		begin
			$error("pixel written into a full FIFO, count %0d", fifoCount);
			failures++;
		end

	// valid only one cycle after a read that found data
	validAfterRead: assert property (@(posedge iCLK) disable iff (reset)
		pixelValid |-> $past(readStrobe && (fifoCount != '0)))
		else
		begin
			$error("pixelValid without an accepted read");
			failures++;
		end

	// flags move only after a frame-last pixel in the fade stage or a scene reset
	flagsOnStep: assert property (@(posedge iCLK) disable iff (reset)
		!$stable({alphaMax, alphaMin}) |-> $past((squareValid && squareLast) || sceneFrameReset))
		else
		begin
			$error("fade flags changed without a level step");
			failures++;
		end

endmodule

// FIFO count and stage flags are internal wires of the top level
bind VideoPixelGen VideoPixelGenChecks fifoFadeChecks (
	.iCLK(iCLK), .reset(reset),
	.fifoCount(fifoCount), .fadeValid(fadeValid), .readStrobe(readStrobe),
	.pixelValid(pixelValid), .squareValid(squareValid), .squareLast(squareLast),
	.sceneFrameReset(sceneFrameReset), .alphaMax(alphaMax), .alphaMin(alphaMin)
);
